//--- apb_iob_periph.f
+incdir+tb
design/apb_pkg.sv
design/iob_pkg.sv
design/apb2iob.sv
design/iob_regfile.sv
design/apb_iob_periph.sv
tb/apb_iob_periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the APB register peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --timescale 1ns/1ps \
   --top-module apb_iob_periph_tb \
   -f apb_iob_periph.f \
   -Mdir obj_dir -o apb_iob_periph_sim

./obj_dir/apb_iob_periph_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- tb/apb_iob_tests.svh
`ifndef APB_IOB_TESTS_SVH
`define APB_IOB_TESTS_SVH

task automatic test_reset();
   int err_before;
   err_before = err_cnt;
   check_value("apb_ready_o after reset", '0, DATA_W'(pready));
   for (int i = 0; i < REG_NUM; i++) begin
      read_and_check(ADDR_W'(i) << BYTE_OFF);
   end
   report_test("test_reset", err_before);
endtask

task automatic test_word_rw();
   int err_before;
   err_before = err_cnt;
   for (int i = 0; i < REG_NUM; i++) begin
      write_and_model(ADDR_W'(i) << BYTE_OFF,
                      {8'(i), 8'hA5 ^ 8'(i), 8'(i * 17), 8'h3C}, '1);  // Distinct per word
   end
   for (int i = 0; i < REG_NUM; i++) begin
      read_and_check(ADDR_W'(i) << BYTE_OFF);
   end
   report_test("test_word_rw", err_before);
endtask

task automatic test_byte_strobe();
   int                err_before;
   logic [STRB_W-1:0] strbs [8];
   err_before = err_cnt;
   strbs = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101, 4'b1010, 4'b0110, 4'b1001};
   for (int w = 0; w < REG_NUM; w += 5) begin
      for (int s = 0; s < 8; s++) begin
         write_and_model(ADDR_W'(w) << BYTE_OFF, $urandom(), strbs[s]);
         read_and_check(ADDR_W'(w) << BYTE_OFF);
      end
   end
   report_test("test_byte_strobe", err_before);
endtask

task automatic test_latency();
   int err_before;
   err_before = err_cnt;
   for (int i = 0; i < REG_NUM; i++) begin
      write_and_model(ADDR_W'(i) << BYTE_OFF, $urandom(), '1);
      check_value("apb_ready_o write latency", DATA_W'(WR_LAT + 2), DATA_W'(last_lat));
      check_value("apb_ready_o after write", '0, DATA_W'(last_ready_held));
      read_and_check(ADDR_W'(i) << BYTE_OFF);
      check_value("apb_ready_o read latency", DATA_W'(RD_LAT + 2), DATA_W'(last_lat));
      check_value("apb_ready_o after read", '0, DATA_W'(last_ready_held));
   end
   report_test("test_latency", err_before);
endtask

task automatic test_out_of_range();
   int                err_before;
   logic [ADDR_W-1:0] bad_addr [3];
   err_before  = err_cnt;
   bad_addr[0] = ADDR_W'(REG_NUM) << BYTE_OFF;        // First word past the bank
   bad_addr[1] = ADDR_W'(REG_NUM + 1) << BYTE_OFF;
   bad_addr[2] = {{(ADDR_W - BYTE_OFF){1'b1}}, {BYTE_OFF{1'b0}}};  // Top of the window
   for (int k = 0; k < 3; k++) begin
      read_and_check(bad_addr[k]);
      write_and_model(bad_addr[k], 32'hFFFF_FFFF, '1);
      read_and_check(bad_addr[k]);
   end
   for (int i = 0; i < REG_NUM; i++) begin
      read_and_check(ADDR_W'(i) << BYTE_OFF);
   end
   report_test("test_out_of_range", err_before);
endtask

task automatic test_random_traffic();
   int                err_before;
   logic [ADDR_W-1:0] addr;
   logic [STRB_W-1:0] strb;
   err_before = err_cnt;
   for (int n = 0; n < 200; n++) begin
      addr = ADDR_W'($urandom_range(REG_NUM - 1, 0)) << BYTE_OFF;
      if ($urandom_range(1, 0) == 1) begin
         // A zero strobe looks like a read to the bank
         strb = STRB_W'($urandom_range((1 << STRB_W) - 1, 1));
         write_and_model(addr, $urandom(), strb);
      end else begin
         read_and_check(addr);
      end
   end
   report_test("test_random_traffic", err_before);
endtask

`endif

//--- tb/apb_iob_periph_tb.sv
module apb_iob_periph_tb
   import apb_pkg::*, iob_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W        = APB_ADDR_W_DEF;
   localparam int DATA_W        = APB_DATA_W_DEF;
   localparam int STRB_W        = DATA_W / 8;
   localparam int BYTE_OFF      = $clog2(STRB_W);
   localparam int REG_NUM       = REG_NUM_DEF;
   localparam int RD_LAT        = int'(RD_LAT_DEF);
   localparam int WR_LAT        = int'(WR_LAT_DEF);
   localparam int READY_TIMEOUT = 50;  // Cycles after setup

   logic              clk = 1'b0;
   logic              rst;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [STRB_W-1:0] pstrb;
   logic [DATA_W-1:0] prdata;
   logic              pready;

   logic [DATA_W-1:0] ref_regs [REG_NUM];  // Expected bank contents
   int                test_cnt;
   int                check_cnt;
   int                err_cnt;
   int                last_lat;         // Setup edge to completion edge
   logic              last_ready_held;  // PREADY seen again after completion

   always #10 clk = ~clk;

   apb_iob_periph u_apb_iob_periph (
      .clk_i       (clk),
      .rst_i       (rst),
      .apb_sel_i   (psel),
      .apb_enable_i(penable),
      .apb_write_i (pwrite),
      .apb_addr_i  (paddr),
      .apb_wdata_i (pwdata),
      .apb_wstrb_i (pstrb),
      .apb_rdata_o (prdata),
      .apb_ready_o (pready)
   );

   // Starts on a falling edge and ends on one, so calls run back to back
   task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                               output logic [DATA_W-1:0] rdata);
      int            waited;
      bridge_phase_t ph;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      pstrb   = strb;
      @(negedge clk);  // Setup edge passed
      penable = 1'b1;
      waited  = 0;
      while (!pready && waited < READY_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!pready) begin
         ph = u_apb_iob_periph.u_bridge.phase;
         $display("PREADY did not arrive within %0d cycles, bridge phase is %s",
                  READY_TIMEOUT, ph.name());
         $display("Test failures found");
         $finish;
      end else begin
         rdata    = prdata;
         last_lat = waited + 1;  // Completion edge follows this falling edge
         @(negedge clk);
         last_ready_held = pready;
         psel    = 1'b0;
         penable = 1'b0;
      end
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] unused_rdata;
      apb_transfer(1'b1, addr, data, strb, unused_rdata);
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      apb_transfer(1'b0, addr, '0, '0, data);
   endtask

   task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] got);
      check_cnt++;
      assert (got === exp) else begin
         $display("CHECK FAILED: %s expected 0x%h got 0x%h", name, exp, got);
         err_cnt++;
      end
   endtask

   // Byte lane merge of a strobed write
   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
                                                     input logic [DATA_W-1:0] new_val,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_val;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = new_val[b*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic write_and_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                  input logic [STRB_W-1:0] strb);
      int word;
      word = int'(addr >> BYTE_OFF);
      apb_write(addr, data, strb);
      if (word < REG_NUM) begin  // Writes beyond the bank are dropped
         ref_regs[word] = merge_bytes(ref_regs[word], data, strb);
      end
   endtask

   task automatic read_and_check(input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] got;
      int                word;
      word = int'(addr >> BYTE_OFF);
      apb_read(addr, got);
      check_value($sformatf("apb_rdata_o at 0x%h", addr),
                  (word < REG_NUM) ? ref_regs[word] : '0, got);
   endtask

   task automatic report_test(input string name, input int err_before);
      test_cnt++;
      if (err_cnt == err_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, err_cnt - err_before);
      end
   endtask

   `include "apb_iob_tests.svh"

   initial begin
      int seed_ret;
      seed_ret        = $urandom(32'hfbcdfa96);
      rst             = 1'b1;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      paddr           = '0;
      pwdata          = '0;
      pstrb           = '0;
      test_cnt        = 0;
      check_cnt       = 0;
      err_cnt         = 0;
      last_lat        = 0;
      last_ready_held = 1'b0;
      for (int i = 0; i < REG_NUM; i++) begin
         ref_regs[i] = '0;  // Bank clears on reset
      end
      repeat (8) @(negedge clk);
      rst = 1'b0;

      test_reset();
      test_word_rw();
      test_byte_strobe();
      test_latency();
      test_out_of_range();
      test_random_traffic();

      $display("Tests run: %0d  checks: %0d  errors: %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- design/apb_iob_periph.sv
module apb_iob_periph
   import apb_pkg::*, iob_pkg::*;
#(
   parameter int       APB_ADDR_W = APB_ADDR_W_DEF,
   parameter int       APB_DATA_W = APB_DATA_W_DEF,
   parameter int       REG_NUM    = REG_NUM_DEF,
   parameter lat_cnt_t RD_LAT     = RD_LAT_DEF,
   parameter lat_cnt_t WR_LAT     = WR_LAT_DEF
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   input  logic                    apb_sel_i,
   input  logic                    apb_enable_i,
   input  logic                    apb_write_i,
   input  logic [APB_ADDR_W-1:0]   apb_addr_i,
   input  logic [APB_DATA_W-1:0]   apb_wdata_i,
   input  logic [APB_DATA_W/8-1:0] apb_wstrb_i,
   output logic [APB_DATA_W-1:0]   apb_rdata_o,
   output logic                    apb_ready_o
);

   // Internal IOb bus matches the APB side
   localparam int ADDR_W = APB_ADDR_W;
   localparam int DATA_W = APB_DATA_W;

   logic                iob_avalid;
   logic [ADDR_W-1:0]   iob_addr;
   logic [DATA_W-1:0]   iob_wdata;
   logic [DATA_W/8-1:0] iob_wstrb;
   logic                iob_rvalid_nxt;
   logic [DATA_W-1:0]   iob_rdata;
   logic                iob_ready_nxt;

   apb2iob #(
      .APB_ADDR_W(APB_ADDR_W),
      .APB_DATA_W(APB_DATA_W),
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W)
   ) u_bridge (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .apb_sel_i       (apb_sel_i),
      .apb_enable_i    (apb_enable_i),
      .apb_write_i     (apb_write_i),
      .apb_addr_i      (apb_addr_i),
      .apb_wdata_i     (apb_wdata_i),
      .apb_wstrb_i     (apb_wstrb_i),
      .apb_rdata_o     (apb_rdata_o),
      .apb_ready_o     (apb_ready_o),
      .iob_avalid_o    (iob_avalid),
      .iob_addr_o      (iob_addr),
      .iob_wdata_o     (iob_wdata),
      .iob_wstrb_o     (iob_wstrb),
      .iob_rvalid_nxt_i(iob_rvalid_nxt),
      .iob_rdata_i     (iob_rdata),
      .iob_ready_nxt_i (iob_ready_nxt)
   );

   iob_regfile #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .REG_NUM(REG_NUM),
      .RD_LAT (RD_LAT),
      .WR_LAT (WR_LAT)
   ) u_regfile (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .iob_avalid_i    (iob_avalid),
      .iob_addr_i      (iob_addr),
      .iob_wdata_i     (iob_wdata),
      .iob_wstrb_i     (iob_wstrb),
      .iob_rvalid_nxt_o(iob_rvalid_nxt),
      .iob_rdata_o     (iob_rdata),
      .iob_ready_nxt_o (iob_ready_nxt)
   );

endmodule

//--- design/iob_regfile.sv
module iob_regfile
   import iob_pkg::*;
#(
   parameter int       ADDR_W  = 12,           // Byte address width
   parameter int       DATA_W  = 32,           // Register width
   parameter int       REG_NUM = REG_NUM_DEF,  // Number of registers
   parameter lat_cnt_t RD_LAT  = RD_LAT_DEF,   // Read wait states
   parameter lat_cnt_t WR_LAT  = WR_LAT_DEF    // Write wait states
) (
   input  logic                clk_i,
   input  logic                rst_i,

   input  logic                iob_avalid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_rvalid_nxt_o,
   output logic [DATA_W-1:0]   iob_rdata_o,
   output logic                iob_ready_nxt_o
);

   localparam int STRB_W   = DATA_W / 8;
   localparam int BYTE_OFF = $clog2(STRB_W);
   localparam int IDX_W    = (REG_NUM > 1) ? $clog2(REG_NUM) : 1;

   logic [DATA_W-1:0] regs [REG_NUM];

   logic              busy;  // Request taken and waiting for avalid to drop
   logic              done;  // Next pulse already issued for this request
   lat_cnt_t          cnt;
   lat_cnt_t          cnt_cur;
   lat_cnt_t          lat;
   logic              is_write;
   logic              pulse;
   logic [ADDR_W-1:0] word_addr;
   logic [IDX_W-1:0]  idx;
   logic              in_range;

   assign is_write = |iob_wstrb_i;
   assign lat      = is_write ? WR_LAT : RD_LAT;

   // First avalid cycle of a request counts as zero
   assign cnt_cur = busy ? cnt : '0;
   assign pulse   = iob_avalid_i && !done && (cnt_cur == lat);

   assign iob_ready_nxt_o  = pulse && is_write;   // Write finished
   assign iob_rvalid_nxt_o = pulse && !is_write;  // Read data lands next cycle

   // Word addressing with the byte offset dropped
   assign word_addr = iob_addr_i >> BYTE_OFF;
   assign in_range  = (word_addr < ADDR_W'(REG_NUM));
   assign idx       = word_addr[IDX_W-1:0];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy <= 1'b0;
         done <= 1'b0;
         cnt  <= '0;
      end else if (!iob_avalid_i) begin  // Bridge back in idle
         busy <= 1'b0;
         done <= 1'b0;
      end else if (!busy) begin  // New request
         busy <= 1'b1;
         done <= pulse;
         cnt  <= lat_cnt_t'(1);
      end else if (!done) begin
         if (pulse) begin
            done <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Storage update on the completing cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (pulse && is_write && in_range) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (iob_wstrb_i[b]) begin
               regs[idx][b*8 +: 8] <= iob_wdata_i[b*8 +: 8];  // Strobed byte only
            end
         end
      end
   end

   // Read data held until the next read completes
   always_ff @(posedge clk_i) begin
      if (pulse && !is_write) begin
         iob_rdata_o <= in_range ? regs[idx] : '0;  // Out of range reads zero
      end
   end

endmodule

//--- design/apb2iob.sv
module apb2iob
   import apb_pkg::*;
#(
   parameter int APB_ADDR_W = APB_ADDR_W_DEF,  // APB address width
   parameter int APB_DATA_W = APB_DATA_W_DEF,  // APB data width
   parameter int ADDR_W     = APB_ADDR_W,      // IOb address width
   parameter int DATA_W     = APB_DATA_W       // IOb data width
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // APB slave side
   input  logic                    apb_sel_i,
   input  logic                    apb_enable_i,
   input  logic                    apb_write_i,
   input  logic [APB_ADDR_W-1:0]   apb_addr_i,
   input  logic [APB_DATA_W-1:0]   apb_wdata_i,
   input  logic [APB_DATA_W/8-1:0] apb_wstrb_i,
   output logic [APB_DATA_W-1:0]   apb_rdata_o,
   output logic                    apb_ready_o,

   // IOb master side
   output logic                    iob_avalid_o,
   output logic [ADDR_W-1:0]       iob_addr_o,
   output logic [DATA_W-1:0]       iob_wdata_o,
   output logic [DATA_W/8-1:0]     iob_wstrb_o,
   input  logic                    iob_rvalid_nxt_i,
   input  logic [DATA_W-1:0]       iob_rdata_i,
   input  logic                    iob_ready_nxt_i
);

   localparam int STRB_W = DATA_W / 8;

   bridge_phase_t phase;
   bridge_phase_t phase_nxt;
   logic          apb_ready_nxt;

   always_comb begin
      phase_nxt     = phase;
      apb_ready_nxt = 1'b0;
      case (phase)
         IDLE: begin
            if (apb_sel_i) begin  // Setup cycle seen
               phase_nxt = ACCESS;
            end
         end
         ACCESS: begin
            // Pick the pulse that matches the transfer direction
            apb_ready_nxt = apb_write_i ? iob_ready_nxt_i : iob_rvalid_nxt_i;
            if (apb_enable_i && apb_ready_o) begin  // Transfer completes
               phase_nxt = IDLE;
            end
         end
         default: begin
            phase_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phase       <= IDLE;
         apb_ready_o <= 1'b0;
      end else begin
         phase       <= phase_nxt;
         apb_ready_o <= apb_ready_nxt;  // One cycle behind the IOb pulse
      end
   end

   assign iob_avalid_o = (phase == ACCESS);

   // Payload is held by the APB master, so it passes straight through
   assign iob_addr_o  = ADDR_W'(apb_addr_i);
   assign iob_wdata_o = DATA_W'(apb_wdata_i);
   assign iob_wstrb_o = apb_write_i ? STRB_W'(apb_wstrb_i) : '0;  // Reads carry no strobe
   assign apb_rdata_o = APB_DATA_W'(iob_rdata_i);

endmodule

//--- design/iob_pkg.sv
package iob_pkg;

   // Register bank size
   localparam int REG_NUM_DEF = 16;  // Number of 32-bit words

   // Wait-state counter, wide enough for latencies 0 to 15
   typedef logic [3:0] lat_cnt_t;

   // Wait states inserted before the next pulse
   localparam lat_cnt_t RD_LAT_DEF = 4'd2;  // Read access
   localparam lat_cnt_t WR_LAT_DEF = 4'd1;  // Write access

endpackage

//--- design/apb_pkg.sv
package apb_pkg;

   // Bus widths used when the top level is not overridden
   localparam int APB_ADDR_W_DEF = 12;  // Byte address, 4 KiB window
   localparam int APB_DATA_W_DEF = 32;  // One word per transfer

   // The bridge keeps a single bit of request state
   typedef enum logic [0:0] {
      IDLE   = 1'b0,  // Waiting for PSEL
      ACCESS = 1'b1   // IOb request outstanding
   } bridge_phase_t;

endpackage
